//--- Bender.yml
package:
  name: conv_pe

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/pe_pkg.sv
      - common/apb_pkg.sv
      - pe/tap_shifter.sv
      - pe/pe_ctrl.sv
      - pe/pe.sv
      - hdl/conv_regs.sv
      - hdl/conv_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/conv_tb.sv

//--- build.f
+incdir+common
common/pe_pkg.sv
common/apb_pkg.sv
pe/tap_shifter.sv
pe/pe_ctrl.sv
pe/pe.sv
hdl/conv_regs.sv
hdl/conv_top.sv
tests/conv_tb.sv

//--- common/apb_pkg.sv
`include "conv_consts.svh"

package apb_pkg;

    // Register select, taken straight from PADDR
    // Offsets outside this set read as zero
    typedef enum logic [4:0] {
        REG_CFG    = `CONV_ADDR_CFG,
        REG_FLTR   = `CONV_ADDR_FLTR,
        REG_IFMAP  = `CONV_ADDR_IFMAP,
        REG_RESULT = `CONV_ADDR_RESULT,
        REG_STATUS = `CONV_ADDR_STATUS
    } conv_reg_e;

    // STATUS word, msb first
    // fifo_count sits in the low bits
    typedef struct packed {
        // Unused, read as zero
        logic [25:0] rsvd;
        // K taps written since the last CFG
        logic        filter_full;
        // K samples written since the last CFG
        logic        window_full;
        // MAC pass still in flight
        logic        busy;
        // Results waiting in the FIFO
        logic [2:0]  fifo_count;
    } conv_status_t;

endpackage

//--- common/conv_consts.svh
`ifndef CONV_CONSTS_SVH
`define CONV_CONSTS_SVH

////////////////////////////////////////////////////
// Datapath sizes
////////////////////////////////////////////////////

// One input sample or filter tap
`define CONV_DATA_W       16

// Product and running partial sum
`define CONV_PSUM_W       32

// Longest kernel the window registers can hold
`define CONV_MAX_KERNEL   5

// Result FIFO entries
`define CONV_FIFO_DEPTH   4

////////////////////////////////////////////////////
// APB register offsets
////////////////////////////////////////////////////

// Kernel size, write resets both fill counts
`define CONV_ADDR_CFG     5'h00
// Push one filter tap
`define CONV_ADDR_FLTR    5'h04
// Push one input sample
`define CONV_ADDR_IFMAP   5'h08
// Pop one partial sum
`define CONV_ADDR_RESULT  5'h0C
// Fill levels and busy flag
`define CONV_ADDR_STATUS  5'h10

`endif

//--- common/pe_pkg.sv
`include "conv_consts.svh"

package pe_pkg;

    // Signed sample or tap
    typedef logic signed [`CONV_DATA_W-1:0] pe_data_t;

    // Signed product, also the accumulator word
    // Sums wrap modulo 2^32
    typedef logic signed [`CONV_PSUM_W-1:0] pe_psum_t;

    // Kernel size, 1 up to CONV_MAX_KERNEL
    typedef logic [2:0] pe_ksize_t;

    // Controller states
    // IDLE   window empty
    // FILL   window partly loaded
    // READY  window holds K samples
    // PASS   rotating the window through the MAC
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        READY,
        PASS
    } pe_state_t;

endpackage

//--- hdl/conv_regs.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_regs import pe_pkg::*, apb_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        tap_push,
    output logic        sample_push,
    output logic        clear,
    output pe_ksize_t   kernel_size,
    output pe_data_t    push_data,
    input  logic        busy,
    input  logic        window_full,
    input  logic        filter_full,
    input  logic        psum_valid,
    input  pe_psum_t    psum
);

    localparam int FIFO_AW = $clog2(`CONV_FIFO_DEPTH);

    conv_reg_e          reg_sel;
    conv_status_t       status;
    logic               access;
    logic               wr;
    logic               rd;
    logic               k_ok;
    logic               ifmap_stall;
    logic               pop;
    logic               fifo_full;
    logic               fifo_empty;
    logic [2:0]         fifo_count;
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    pe_psum_t           fifo_mem [`CONV_FIFO_DEPTH];

    ////////////////////////////////////////////////////
    // APB decode
    ////////////////////////////////////////////////////

    assign reg_sel = conv_reg_e'(paddr);
    assign access  = psel && penable;

    // While busy the owed result is not in fifo_count yet,
    // so a new pass waits for it to land
    assign ifmap_stall = busy || fifo_full;

    // Only IFMAP writes ever wait
    assign pready = access && !(pwrite && reg_sel == REG_IFMAP && ifmap_stall);

    // Completed transfers
    assign wr = pready && pwrite;
    assign rd = pready && !pwrite;

    // Legal kernel sizes
    assign k_ok = (pwdata != 32'd0) && (pwdata <= `CONV_MAX_KERNEL);

    // One-cycle strobes into the PE
    assign tap_push    = wr && reg_sel == REG_FLTR && !filter_full;
    assign sample_push = wr && reg_sel == REG_IFMAP;
    assign clear       = wr && reg_sel == REG_CFG && k_ok;
    assign push_data   = pe_data_t'(pwdata[`CONV_DATA_W-1:0]);

    assign pop = rd && reg_sel == REG_RESULT && !fifo_empty;

    // Bad accesses still complete, nothing changes
    assign pslverr = pready && (
        (!pwrite && reg_sel == REG_RESULT && fifo_empty) ||
        (pwrite && reg_sel == REG_CFG && !k_ok) ||
        (pwrite && reg_sel == REG_FLTR && filter_full));

    // K comes up as 1
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            kernel_size <= 3'd1;
        end else if (clear) begin
            kernel_size <= pe_ksize_t'(pwdata[2:0]);
        end
    end

    ////////////////////////////////////////////////////
    // Result FIFO
    ////////////////////////////////////////////////////

    // Stall rule keeps room for every strobe
    always_ff @(posedge clk) begin
        if (psum_valid) begin
            fifo_mem[wr_ptr] <= psum;
        end
    end

    // Depth is a power of two, pointers wrap on their own
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (psum_valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({psum_valid, pop})
                2'b10:   fifo_count <= fifo_count + 3'd1;
                2'b01:   fifo_count <= fifo_count - 3'd1;
                default: fifo_count <= fifo_count;
            endcase
        end
    end

    assign fifo_full  = (fifo_count == `CONV_FIFO_DEPTH);
    assign fifo_empty = (fifo_count == 3'd0);

    ////////////////////////////////////////////////////
    // Read data
    ////////////////////////////////////////////////////

    always_comb begin
        status             = '0;
        status.fifo_count  = fifo_count;
        status.busy        = busy;
        status.window_full = window_full;
        status.filter_full = filter_full;
    end

    // Head of the FIFO shows up in the same access phase
    always_comb begin
        prdata = '0;
        if (psel && !pwrite) begin
            case (reg_sel)
                REG_CFG:    prdata = 32'(kernel_size);
                REG_RESULT: prdata = fifo_empty ? '0 : fifo_mem[rd_ptr];
                REG_STATUS: prdata = status;
                default:    prdata = '0;
            endcase
        end
    end

    // A PE strobe into a full FIFO means the stall rule slipped
    a_fifo_no_overflow: assert property (
        @(posedge clk) disable iff (!rstn)
        psum_valid |-> (!fifo_full || pop)
    ) else $error("result FIFO overflow");

endmodule

//--- hdl/conv_top.sv
`timescale 1ns/1ps

module conv_top import pe_pkg::*; (
    input  logic        clk,
    input  logic        rstn,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [4:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // Register block to PE
    logic      tap_push;
    logic      sample_push;
    logic      clear;
    pe_ksize_t kernel_size;
    pe_data_t  push_data;
    // PE back to register block
    logic      busy;
    logic      window_full;
    logic      filter_full;
    logic      psum_valid;
    pe_psum_t  psum;

    conv_regs u_regs (
        .clk         (clk),
        .rstn        (rstn),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .tap_push    (tap_push),
        .sample_push (sample_push),
        .clear       (clear),
        .kernel_size (kernel_size),
        .push_data   (push_data),
        .busy        (busy),
        .window_full (window_full),
        .filter_full (filter_full),
        .psum_valid  (psum_valid),
        .psum        (psum)
    );

    pe u_pe (
        .clk         (clk),
        .rstn        (rstn),
        .tap_push    (tap_push),
        .sample_push (sample_push),
        .clear       (clear),
        .kernel_size (kernel_size),
        .push_data   (push_data),
        .busy        (busy),
        .window_full (window_full),
        .filter_full (filter_full),
        .psum_valid  (psum_valid),
        .psum        (psum)
    );

endmodule

//--- pe/pe.sv
`timescale 1ns/1ps

module pe import pe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      tap_push,
    input  logic      sample_push,
    input  logic      clear,
    input  pe_ksize_t kernel_size,
    input  pe_data_t  push_data,
    output logic      busy,
    output logic      window_full,
    output logic      filter_full,
    output logic      psum_valid,
    output pe_psum_t  psum
);

    logic     rotate;
    logic     acc_first;
    pe_data_t fltr_tap;
    pe_data_t ifmap_smp;
    // Product pipe and accumulator
    pe_psum_t prod_s1;
    pe_psum_t prod_s2;
    pe_psum_t acc_q;
    pe_psum_t acc_sum;

    ////////////////////////////////////////////////////
    // Window registers
    ////////////////////////////////////////////////////

    // Taps in write order, w[0] comes out first
    tap_shifter u_fltr (
        .clk    (clk),
        .rstn   (rstn),
        .load   (tap_push),
        .rotate (rotate),
        .depth  (kernel_size),
        .din    (push_data),
        .dout   (fltr_tap)
    );

    // Last K samples, oldest comes out first
    tap_shifter u_ifmap (
        .clk    (clk),
        .rstn   (rstn),
        .load   (sample_push),
        .rotate (rotate),
        .depth  (kernel_size),
        .din    (push_data),
        .dout   (ifmap_smp)
    );

    pe_ctrl u_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .tap_push    (tap_push),
        .sample_push (sample_push),
        .clear       (clear),
        .kernel_size (kernel_size),
        .rotate      (rotate),
        .acc_first   (acc_first),
        .busy        (busy),
        .window_full (window_full),
        .filter_full (filter_full),
        .psum_valid  (psum_valid)
    );

    ////////////////////////////////////////////////////
    // MAC
    ////////////////////////////////////////////////////

    // Signed 16x16, two register stages
    always_ff @(posedge clk) begin
        prod_s1 <= fltr_tap * ifmap_smp;
        prod_s2 <= prod_s1;
    end

    // First product of a pass restarts the sum
    assign acc_sum = acc_first ? prod_s2 : acc_q + prod_s2;

    // Junk in the first two busy cycles is overwritten by acc_first
    always_ff @(posedge clk) begin
        if (busy) begin
            acc_q <= acc_sum;
        end
    end

    // Final sum leaves with the strobe, then sits in acc_q
    assign psum = psum_valid ? acc_sum : acc_q;

endmodule

//--- pe/pe_ctrl.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module pe_ctrl import pe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      tap_push,
    input  logic      sample_push,
    input  logic      clear,
    input  pe_ksize_t kernel_size,
    output logic      rotate,
    output logic      acc_first,
    output logic      busy,
    output logic      window_full,
    output logic      filter_full,
    output logic      psum_valid
);

    pe_state_t state;
    pe_ksize_t tap_cnt;
    pe_ksize_t win_cnt;
    pe_ksize_t step;
    logic      start;
    logic      last_step;
    // Pass markers, aligned with the two multiplier stages
    logic      first_d1;
    logic      first_d2;
    logic      last_d1;
    logic      last_d2;

    assign rotate    = (state == PASS);
    assign last_step = rotate && (step == kernel_size - 3'd1);

    // This push completes the window
    assign start = sample_push && !rotate && (win_cnt + 3'd1 >= kernel_size);

    ////////////////////////////////////////////////////
    // Fill counts
    ////////////////////////////////////////////////////

    // Saturate at K, later pushes just slide the window
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            tap_cnt <= '0;
            win_cnt <= '0;
        end else if (clear) begin
            tap_cnt <= '0;
            win_cnt <= '0;
        end else begin
            if (tap_push && tap_cnt < kernel_size) begin
                tap_cnt <= tap_cnt + 3'd1;
            end
            if (sample_push && win_cnt < kernel_size) begin
                win_cnt <= win_cnt + 3'd1;
            end
        end
    end

    assign window_full = (win_cnt == kernel_size);
    assign filter_full = (tap_cnt == kernel_size);

    ////////////////////////////////////////////////////
    // Pass FSM
    ////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            step  <= '0;
        end else if (clear) begin
            state <= IDLE;
            step  <= '0;
        end else begin
            case (state)
                IDLE, FILL, READY: begin
                    if (start) begin
                        state <= PASS;
                        step  <= '0;
                    end else if (sample_push) begin
                        state <= FILL;
                    end
                end
                PASS: begin
                    // K rotations, window order restored at the end
                    if (last_step) begin
                        state <= READY;
                        step  <= '0;
                    end else begin
                        step <= step + 3'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Follow the products down the multiplier pipe
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            first_d1 <= 1'b0;
            first_d2 <= 1'b0;
            last_d1  <= 1'b0;
            last_d2  <= 1'b0;
        end else begin
            first_d1 <= rotate && (step == '0);
            first_d2 <= first_d1;
            last_d1  <= last_step;
            last_d2  <= last_d1;
        end
    end

    assign acc_first  = first_d2;
    assign psum_valid = last_d2;
    // Rotation plus the two drain cycles
    assign busy = rotate || last_d1 || last_d2;

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////

    // The APB side must hold IFMAP writes off during a pass
    a_no_push_busy: assert property (
        @(posedge clk) disable iff (!rstn)
        !(sample_push && busy)
    ) else $error("sample push while PE busy");

    // CFG range check lives in the register block
    a_ksize_range: assert property (
        @(posedge clk) disable iff (!rstn)
        kernel_size >= 3'd1 && kernel_size <= `CONV_MAX_KERNEL
    ) else $error("kernel size out of range");

    // One result per pass, passes are at least K+2 apart
    a_valid_gap: assert property (
        @(posedge clk) disable iff (!rstn)
        (psum_valid && kernel_size > 3'd1) |=> !psum_valid
    ) else $error("back to back psum_valid");

endmodule

//--- pe/tap_shifter.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module tap_shifter import pe_pkg::*; (
    input  logic      clk,
    input  logic      rstn,
    input  logic      load,
    input  logic      rotate,
    input  pe_ksize_t depth,
    input  pe_data_t  din,
    output pe_data_t  dout
);

    // slot[0] oldest, slot[depth-1] newest
    pe_data_t slot [`CONV_MAX_KERNEL];
    pe_data_t feed;

    // Load takes new data, rotate recirculates the oldest
    assign feed = load ? din : slot[0];

    ////////////////////////////////////////////////////
    // Window register
    ////////////////////////////////////////////////////

    // Both ops move every live entry one step toward slot 0
    // Entries above depth-1 stay untouched
    always_ff @(posedge clk) begin
        if (load || rotate) begin
            for (int i = 0; i < `CONV_MAX_KERNEL - 1; i++) begin
                if (i < int'(depth) - 1) begin
                    slot[i] <= slot[i + 1];
                end
            end
            // Newest position takes the feed word
            slot[depth - 3'd1] <= feed;
        end
    end

    // Oldest first, so a full rotation walks the window in order
    assign dout = slot[0];

    ////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////

    // A push in the middle of a pass would shear the window
    a_no_load_in_rotate: assert property (
        @(posedge clk) disable iff (!rstn)
        !(load && rotate)
    ) else $error("tap_shifter load during rotate");

endmodule

//--- tests/conv_tb.sv
`timescale 1ns/1ps
`include "conv_consts.svh"

module conv_tb
    import pe_pkg::*, apb_pkg::*;
();

    localparam int NUM_VEC      = 6;
    localparam int APB_TIMEOUT  = 64;
    localparam int POLL_LIMIT   = 40;
    localparam int STALL_CYCLES = 12;

    // One table row with taps[0] written first
    typedef struct packed {
        logic [2:0]                         k;
        logic [0:`CONV_MAX_KERNEL-1][15:0]  taps;
        logic [5:0]                         nsamp;
        logic                               fixed;
        logic [15:0]                        fixed_val;
        logic                               hold;
    } vec_t;

    logic        clk = 1'b0;
    logic        rstn;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    vec_t        vec_table [NUM_VEC];
    pe_data_t    cur_taps [`CONV_MAX_KERNEL];
    pe_data_t    smp_hist [64];
    pe_psum_t    exp_q [$];
    logic [31:0] lfsr_state = 32'h943174d0;

    conv_top u_dut (
        .clk     (clk),
        .rstn    (rstn),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 100 ns period
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // Error reporting and compares
    //////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_psum(input string name, input pe_psum_t got, input pe_psum_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic check_status(input conv_status_t got, input conv_status_t exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: status got 0x%h expected 0x%h", got, exp));
        end
    endtask

    task automatic check_err(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("CHECK FAILED: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic conv_status_t make_status(input int count, input logic bsy,
                                                 input logic wfull, input logic ffull);
        conv_status_t st;
        st             = '0;
        st.fifo_count  = 3'(count);
        st.busy        = bsy;
        st.window_full = wfull;
        st.filter_full = ffull;
        return st;
    endfunction

    //////////////////////////////////////////////////
    // Stimulus sources and reference model
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per sample bit
    function automatic pe_data_t random_sample();
        pe_data_t v;
        v = '0;
        for (int b = 0; b < `CONV_DATA_W; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v[b]       = lfsr_state[0];
        end
        return v;
    endfunction

    // y[n] = sum of w[j] * x[n-K+1+j] modulo 2^32
    function automatic pe_psum_t conv_model(input int k, input int n);
        pe_psum_t acc;
        acc = '0;
        for (int j = 0; j < k; j++) begin
            acc = acc + pe_psum_t'(cur_taps[j]) * pe_psum_t'(smp_hist[n - k + 1 + j]);
        end
        return acc;
    endfunction

    function automatic vec_t make_vec(input int k, input logic [0:4][15:0] taps,
                                      input int nsamp, input logic fixed,
                                      input logic [15:0] fixed_val, input logic hold);
        vec_t v;
        v.k         = 3'(k);
        v.taps      = taps;
        v.nsamp     = 6'(nsamp);
        v.fixed     = fixed;
        v.fixed_val = fixed_val;
        v.hold      = hold;
        return v;
    endfunction

    //////////////////////////////////////////////////
    // APB master
    //////////////////////////////////////////////////

    // Setup phase followed by access phase until pready
    task automatic apb_access(input logic wr, input conv_reg_e addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int waits;
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;
        waits   = 0;
        // Outputs are settled by the falling edge
        @(negedge clk);
        while (!pready) begin
            waits++;
            if (waits > APB_TIMEOUT) begin
                abort_run($sformatf("APB access to 0x%h never saw pready", addr));
            end
            @(negedge clk);
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input conv_reg_e addr, input logic [31:0] wdata, output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, unused, err);
    endtask

    task automatic apb_read(input conv_reg_e addr, output logic [31:0] rdata, output logic err);
        apb_access(1'b0, addr, 32'h0, rdata, err);
    endtask

    task automatic read_status(output conv_status_t st);
        logic [31:0] rdata;
        logic        err;
        apb_read(REG_STATUS, rdata, err);
        check_err("pslverr", err, 1'b0);
        st = conv_status_t'(rdata);
    endtask

    // Hold an IFMAP write against a full FIFO and then back off
    task automatic probe_stall(input pe_data_t x);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = REG_IFMAP;
        pwdata  = {16'h0, x};
        @(posedge clk);
        #1;
        penable = 1'b1;
        repeat (STALL_CYCLES) begin
            @(negedge clk);
            check_err("pready", pready, 1'b0);
            @(posedge clk);
            #1;
        end
        // Never completed so the same sample goes out again later
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    //////////////////////////////////////////////////
    // Result handling
    //////////////////////////////////////////////////

    // Poll until the PE is idle and all owed results landed
    task automatic wait_results(input int count);
        conv_status_t st;
        int           polls;
        polls = 0;
        read_status(st);
        while (st.busy || st.fifo_count != 3'(count)) begin
            polls++;
            if (polls > POLL_LIMIT) begin
                abort_run($sformatf("STATUS never reached %0d results with PE idle", count));
            end
            read_status(st);
        end
        check_status(st, make_status(count, 1'b0, 1'b1, 1'b1));
    endtask

    task automatic pop_result();
        logic [31:0] rdata;
        logic        err;
        apb_read(REG_RESULT, rdata, err);
        check_err("pslverr", err, 1'b0);
        check_psum("prdata", pe_psum_t'(rdata), exp_q.pop_front());
    endtask

    task automatic drain_results();
        while (exp_q.size() > 0) begin
            pop_result();
        end
    endtask

    //////////////////////////////////////////////////
    // One table row
    //////////////////////////////////////////////////

    task automatic run_entry(input vec_t v);
        int           k;
        int           n;
        pe_data_t     x;
        logic [31:0]  rdata;
        logic         err;
        conv_status_t st;
        k = int'(v.k);
        n = int'(v.nsamp);
        // Fresh kernel size drops both fill flags
        apb_write(REG_CFG, {29'h0, v.k}, err);
        check_err("pslverr", err, 1'b0);
        read_status(st);
        check_status(st, make_status(0, 1'b0, 1'b0, 1'b0));
        for (int j = 0; j < k; j++) begin
            cur_taps[j] = pe_data_t'(v.taps[j]);
            apb_write(REG_FLTR, {16'h0, v.taps[j]}, err);
            check_err("pslverr", err, 1'b0);
        end
        // Rejected writes must leave the config intact
        apb_write(REG_FLTR, 32'h0000_5a5a, err);
        check_err("pslverr", err, 1'b1);
        apb_write(REG_CFG, 32'd0, err);
        check_err("pslverr", err, 1'b1);
        apb_write(REG_CFG, 32'd6, err);
        check_err("pslverr", err, 1'b1);
        read_status(st);
        check_status(st, make_status(0, 1'b0, 1'b0, 1'b1));
        for (int i = 0; i < n; i++) begin
            if (v.fixed) begin
                x = pe_data_t'(v.fixed_val);
            end else begin
                x = random_sample();
            end
            smp_hist[i] = x;
            // With the FIFO full this push has to wait for a read
            if (v.hold && i >= k - 1 && exp_q.size() == `CONV_FIFO_DEPTH) begin
                wait_results(`CONV_FIFO_DEPTH);
                probe_stall(x);
                pop_result();
            end
            apb_write(REG_IFMAP, {16'h0, x}, err);
            check_err("pslverr", err, 1'b0);
            if (i >= k - 1) begin
                exp_q.push_back(conv_model(k, i));
            end else begin
                // Nothing may come out while the window fills
                read_status(st);
                check_status(st, make_status(0, 1'b0, 1'b0, 1'b1));
            end
            if (!v.hold && exp_q.size() > 0) begin
                wait_results(exp_q.size());
                drain_results();
            end
        end
        wait_results(exp_q.size());
        drain_results();
        // Empty FIFO answers zero with an error
        apb_read(REG_RESULT, rdata, err);
        check_psum("prdata", pe_psum_t'(rdata), '0);
        check_err("pslverr", err, 1'b1);
    endtask

    //////////////////////////////////////////////////
    // Main sequence
    //////////////////////////////////////////////////

    initial begin
        logic [31:0]  rdata;
        logic         err;
        conv_status_t st;
        rstn    = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;

        // Columns are K, taps, samples, fixed flag, fixed value and hold
        vec_table[0] = make_vec(1, {16'h0003, 16'h0, 16'h0, 16'h0, 16'h0}, 6, 0, 16'h0, 0);
        vec_table[1] = make_vec(3, {16'hfffe, 16'h0005, 16'h7fff, 16'h0, 16'h0}, 8, 0, 16'h0, 0);
        // Five max-negative products overflow 32 bits
        vec_table[2] = make_vec(5, {16'h8000, 16'h8000, 16'h8000, 16'h8000, 16'h8000}, 7,
                                1, 16'h8000, 0);
        vec_table[3] = make_vec(5, {16'h0001, 16'hffff, 16'h1234, 16'h8000, 16'h7fff}, 9,
                                0, 16'h0, 0);
        vec_table[4] = make_vec(2, {16'hffff, 16'h8000, 16'h0, 16'h0, 16'h0}, 5, 1, 16'h7fff, 0);
        // One result more than the FIFO holds
        vec_table[5] = make_vec(4, {16'h0102, 16'hfedc, 16'h8001, 16'h0007, 16'h0},
                                4 + `CONV_FIFO_DEPTH, 0, 16'h0, 1);

        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;

        // Idle outputs after reset
        @(negedge clk);
        check_err("pready", pready, 1'b0);
        check_err("pslverr", pslverr, 1'b0);
        read_status(st);
        check_status(st, make_status(0, 1'b0, 1'b0, 1'b0));
        apb_read(REG_RESULT, rdata, err);
        check_psum("prdata", pe_psum_t'(rdata), '0);
        check_err("pslverr", err, 1'b1);

        for (int e = 0; e < NUM_VEC; e++) begin
            run_entry(vec_table[e]);
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule
